/* rtl/mem_path_pkg.sv */
package mem_path_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // bit 16 picks sram bank 0 or 1
    localparam int BANK_SEL_BIT = 16;
    // word index sits between the byte offset and the bank bit
    localparam int WORD_W = BANK_SEL_BIT - 2;
    localparam logic [ADDR_W-1:0] MAP_LIMIT = 32'h0002_0000;

    typedef enum logic [1:0] {
        OP_LOAD       = 2'd0,
        OP_STORE      = 2'd1,
        OP_LOAD_RES   = 2'd2,
        OP_STORE_COND = 2'd3
    } mem_op_t;

    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_PROT   = 2'd1,
        FAULT_DECODE = 2'd2
    } fault_t;

    typedef struct packed {
        mem_op_t             op;
        logic [ADDR_W-1:0]   addr;
        logic [STRB_W-1:0]   strb;
        logic [DATA_W-1:0]   wdata;
    } mem_req_t;

    // base and limit are both inclusive
    typedef struct packed {
        logic                en;
        logic                r;
        logic                w;
        logic [ADDR_W-1:0]   base;
        logic [ADDR_W-1:0]   limit;
    } region_cfg_t;

    typedef struct packed {
        mem_op_t             op;
        logic [STRB_W-1:0]   strb;
        logic [DATA_W-1:0]   wdata;
        logic                bank;
        logic [WORD_W-1:0]   word;
        fault_t              fault;
    } checked_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        fault_t              fault;
        logic                sc_fail;
    } mem_resp_t;

endpackage

/* rtl/access_check.sv */
`timescale 1ns/10ps

module access_check
    import mem_path_pkg::*;
#(
    parameter int NUM_REGIONS = 4,
    parameter int BANK_WORDS  = 16384
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           req_valid,
    input  mem_req_t                       req,

    input  logic                           cfg_we,
    input  logic [$clog2(NUM_REGIONS)-1:0] cfg_idx,
    input  region_cfg_t                    cfg_region,

    output logic                           chk_valid,
    output checked_req_t                   chk
);

    region_cfg_t          region_tab [NUM_REGIONS];

    logic [WORD_W-1:0]    word_idx;
    logic                 need_w;
    logic                 unmapped;
    logic                 hit;
    logic                 allow;
    fault_t               fault;

    // region table, disabled out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                region_tab[i].en <= 1'b0;
            end
        end else if (cfg_we) begin
            region_tab[cfg_idx] <= cfg_region;
        end
    end

    assign word_idx = req.addr[BANK_SEL_BIT-1:2];

    // stores and sc need write permission, loads and lr need read
    assign need_w = (req.op == OP_STORE) || (req.op == OP_STORE_COND);

    // above both banks or past the populated depth of a bank
    assign unmapped = (req.addr >= MAP_LIMIT) || (int'(word_idx) >= BANK_WORDS);

    // lowest numbered enabled region wins
    always_comb begin
        hit   = 1'b0;
        allow = 1'b0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (!hit && region_tab[i].en &&
                req.addr >= region_tab[i].base &&
                req.addr <= region_tab[i].limit) begin
                hit   = 1'b1;
                allow = need_w ? region_tab[i].w : region_tab[i].r;
            end
        end
    end

    always_comb begin
        if (unmapped) begin
            fault = FAULT_DECODE;
        end else if (hit && allow) begin
            fault = FAULT_NONE;
        end else begin
            // no region, or the matching one denies the access
            fault = FAULT_PROT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            chk.op    <= req.op;
            chk.strb  <= req.strb;
            chk.wdata <= req.wdata;
            chk.bank  <= req.addr[BANK_SEL_BIT];
            chk.word  <= word_idx;
            chk.fault <= fault;
        end
    end

endmodule

/* rtl/excl_monitor.sv */
`timescale 1ns/10ps

module excl_monitor
    import mem_path_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         chk_valid,
    input  checked_req_t chk,

    output logic         sc_ok
);

    logic                resv_valid;
    logic                resv_bank;
    logic [WORD_W-1:0]   resv_word;

    logic                live;
    logic                match;

    // only non-faulting items touch the reservation
    assign live  = chk_valid && (chk.fault == FAULT_NONE);
    assign match = resv_valid && (resv_bank == chk.bank) && (resv_word == chk.word);

    assign sc_ok = live && (chk.op == OP_STORE_COND) && match;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resv_valid <= 1'b0;
        end else if (live) begin
            case (chk.op)
                OP_LOAD_RES: begin
                    resv_valid <= 1'b1;
                    resv_bank  <= chk.bank;
                    resv_word  <= chk.word;
                end
                // sc consumes the reservation, pass or fail
                OP_STORE_COND: resv_valid <= 1'b0;
                OP_STORE: begin
                    if (match) begin
                        resv_valid <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/bank_access.sv */
`timescale 1ns/10ps

module bank_access
    import mem_path_pkg::*;
#(
    parameter int BANK_WORDS = 16384
) (
    input  logic         clk,
    input  logic         rst_n,

    input  logic         chk_valid,
    input  checked_req_t chk,
    input  logic         sc_ok,

    output logic         resp_valid,
    output mem_resp_t    resp
);

    // two sram banks, selected by chk.bank
    logic [DATA_W-1:0]   mem [2][BANK_WORDS];

    logic                live;
    logic                is_sc;
    logic                wr_en;
    logic                rd_en;

    assign live  = chk_valid && (chk.fault == FAULT_NONE);
    assign is_sc = live && (chk.op == OP_STORE_COND);

    // sc writes only when the monitor still holds the reservation
    assign wr_en = live && ((chk.op == OP_STORE) || (is_sc && sc_ok));
    assign rd_en = live && ((chk.op == OP_LOAD) || (chk.op == OP_LOAD_RES));

    // byte strobed write at the end of the stage 2 cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (chk.strb[b]) begin
                    mem[chk.bank][chk.word][b*8 +: 8] <= chk.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= chk_valid;
        end
    end

    // read sees the word as it was before this cycle's write
    always_ff @(posedge clk) begin
        if (chk_valid) begin
            if (rd_en) begin
                resp.rdata <= mem[chk.bank][chk.word];
            end else begin
                resp.rdata <= '0;
            end
            resp.fault   <= chk.fault;
            resp.sc_fail <= is_sc && !sc_ok;
        end
    end

endmodule

/* rtl/mem_path_top.sv */
`timescale 1ns/10ps

module mem_path_top
    import mem_path_pkg::*;
#(
    parameter int NUM_REGIONS = 4,
    parameter int BANK_WORDS  = 16384
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           req_valid,
    input  mem_req_t                       req,

    input  logic                           cfg_we,
    input  logic [$clog2(NUM_REGIONS)-1:0] cfg_idx,
    input  region_cfg_t                    cfg_region,

    output logic                           resp_valid,
    output mem_resp_t                      resp
);

    logic          chk_valid;
    checked_req_t  chk;
    logic          sc_ok;

    // stage 1, decode and protection
    access_check #(
        .NUM_REGIONS ( NUM_REGIONS ),
        .BANK_WORDS  ( BANK_WORDS  )
    ) u_access_check (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .req_valid  ( req_valid  ),
        .req        ( req        ),
        .cfg_we     ( cfg_we     ),
        .cfg_idx    ( cfg_idx    ),
        .cfg_region ( cfg_region ),
        .chk_valid  ( chk_valid  ),
        .chk        ( chk        )
    );

    excl_monitor u_excl_monitor (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .chk_valid ( chk_valid ),
        .chk       ( chk       ),
        .sc_ok     ( sc_ok     )
    );

    // stage 2, sram banks and response
    bank_access #(
        .BANK_WORDS ( BANK_WORDS )
    ) u_bank_access (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .chk_valid  ( chk_valid  ),
        .chk        ( chk        ),
        .sc_ok      ( sc_ok      ),
        .resp_valid ( resp_valid ),
        .resp       ( resp       )
    );

endmodule

/* verification/mem_path_checker.sv */
`timescale 1ns/10ps

module mem_path_checker
    import mem_path_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  logic       resp_valid,
    input  mem_resp_t  resp
);

    // fixed two cycle latency, checked both ways
    assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> ##2 resp_valid)
        else $error("resp_valid missing two cycles after req_valid");
    assert property (@(posedge clk) disable iff (!rst_n) resp_valid |-> $past(req_valid, 2))
        else $error("resp_valid without a request two cycles earlier");

    // pipeline drains while in reset
    assert property (@(posedge clk) $rose(rst_n) |-> !resp_valid ##1 !resp_valid)
        else $error("resp_valid high right after reset release");

    assert property (@(posedge clk) disable iff (!rst_n)
            (resp_valid && resp.fault != FAULT_NONE) |-> resp.rdata == '0)
        else $error("faulting response carries nonzero rdata");

endmodule

bind mem_path_top mem_path_checker chk0 (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .req_valid  ( req_valid  ),
    .resp_valid ( resp_valid ),
    .resp       ( resp       )
);

/* verification/mem_path_tb.sv */
`timescale 1ns/10ps

module mem_path_tb
    import mem_path_pkg::*;
();

    localparam int NUM_REGIONS    = 4;
    localparam int BANK_WORDS     = 16384;
    localparam int TIMEOUT_CYCLES = 50;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    mem_req_t     req;
    logic         cfg_we;
    logic [1:0]   cfg_idx;
    region_cfg_t  cfg_region;
    logic         resp_valid;
    mem_resp_t    resp;

    // shadow state of the reference model
    logic [DATA_W-1:0] shadow_mem [int];
    region_cfg_t       shadow_regions [NUM_REGIONS];
    logic              resv_valid;
    int                resv_key;
    mem_resp_t         expected_q [$];
    mem_resp_t         head;
    int                n_errors;
    int                n_checks;
    integer            seed;
    logic [31:0]       addr;

    mem_path_top #(
        .NUM_REGIONS ( NUM_REGIONS ),
        .BANK_WORDS  ( BANK_WORDS  )
    ) dut0 (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .req_valid  ( req_valid  ),
        .req        ( req        ),
        .cfg_we     ( cfg_we     ),
        .cfg_idx    ( cfg_idx    ),
        .cfg_region ( cfg_region ),
        .resp_valid ( resp_valid ),
        .resp       ( resp       )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // expected response for one request, advancing the shadow state
    function automatic mem_resp_t model_access(input mem_req_t rq);
        mem_resp_t   exp_resp;
        int          key;
        logic        found;
        logic        permit;
        logic [31:0] cur;
        exp_resp = '0;
        key      = int'(rq.addr[16:2]);
        found    = 1'b0;
        permit   = 1'b0;
        if (rq.addr >= 32'h0002_0000 || int'(rq.addr[15:2]) >= BANK_WORDS) begin
            exp_resp.fault = FAULT_DECODE;
            return exp_resp;
        end
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (!found && shadow_regions[i].en && rq.addr >= shadow_regions[i].base
                    && rq.addr <= shadow_regions[i].limit) begin
                found  = 1'b1;
                permit = (rq.op == OP_STORE || rq.op == OP_STORE_COND) ?
                         shadow_regions[i].w : shadow_regions[i].r;
            end
        end
        if (!permit) begin
            exp_resp.fault = FAULT_PROT;
            return exp_resp;
        end
        cur = shadow_mem.exists(key) ? shadow_mem[key] : 'x;
        case (rq.op)
            OP_LOAD: exp_resp.rdata = cur;
            OP_LOAD_RES: begin
                exp_resp.rdata = cur;
                resv_valid     = 1'b1;
                resv_key       = key;
            end
            OP_STORE: begin
                shadow_mem[key] = merge_bytes(cur, rq.wdata, rq.strb);
                if (resv_valid && resv_key == key) resv_valid = 1'b0;
            end
            default: begin
                if (resv_valid && resv_key == key) begin
                    shadow_mem[key] = merge_bytes(cur, rq.wdata, rq.strb);
                end else begin
                    exp_resp.sc_fail = 1'b1;
                end
                resv_valid = 1'b0;
            end
        endcase
        return exp_resp;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic send_req(input mem_op_t op, input logic [31:0] a,
                            input logic [3:0] strb, input logic [31:0] wdata);
        mem_req_t rq;
        rq = '{op: op, addr: a, strb: strb, wdata: wdata};
        @(negedge clk);
        req_valid = 1'b1;
        req       = rq;
        expected_q.push_back(model_access(rq));
    endtask

    task automatic write_region(input int idx, input logic rd, input logic wr,
                                input logic [31:0] base, input logic [31:0] limit);
        region_cfg_t cfg;
        cfg = '{en: 1'b1, r: rd, w: wr, base: base, limit: limit};
        @(negedge clk);
        req_valid           = 1'b0;
        cfg_we              = 1'b1;
        cfg_idx             = idx[1:0];
        cfg_region          = cfg;
        shadow_regions[idx] = cfg;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic drain_responses();
        int waited;
        @(negedge clk);
        req_valid = 1'b0;
        waited    = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            n_errors++;
            $display("timeout: %0d responses never arrived", expected_q.size());
            expected_q.delete();
        end
    endtask

    // responses settle after the rising edge, sample them on the falling one
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            if (expected_q.size() == 0) begin
                n_errors++;
                $display("response arrived with no request outstanding");
            end else begin
                head = expected_q.pop_front();
                check_value("resp.rdata", resp.rdata, head.rdata);
                check_value("resp.fault", resp.fault, head.fault);
                check_value("resp.sc_fail", resp.sc_fail, head.sc_fail);
            end
        end
    end

    initial begin
        seed       = 32'h28d7;
        n_errors   = 0;
        n_checks   = 0;
        resv_valid = 1'b0;
        resv_key   = 0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        cfg_we     = 1'b0;
        cfg_idx    = '0;
        cfg_region = '0;
        for (int i = 0; i < NUM_REGIONS; i++) shadow_regions[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // empty region table
        send_req(OP_LOAD, 32'h0000_0100, 4'hf, 32'h0);
        drain_responses();

        // region 1 read-write over both banks, random strobed traffic
        write_region(1, 1'b1, 1'b1, 32'h0, 32'h0001_ffff);
        for (int i = 0; i < 12; i++) begin
            addr = $random(seed) & 32'h0001_fffc;
            send_req(OP_STORE, addr, 4'hf, $random(seed));
            send_req(OP_STORE, addr, $random(seed), $random(seed));
            send_req(OP_LOAD, addr, 4'h0, 32'h0);
        end
        send_req(OP_STORE, 32'h0000_0200, 4'hf, 32'h1122_3344);
        send_req(OP_LOAD, 32'h0000_0200, 4'h0, 32'h0);
        send_req(OP_STORE, 32'h0000_0200, 4'b0101, 32'haabb_ccdd);
        send_req(OP_LOAD, 32'h0000_0200, 4'h0, 32'h0);
        send_req(OP_STORE, 32'h0000_0300, 4'hf, 32'hcafe_0300);
        send_req(OP_STORE, 32'h0000_0400, 4'hf, 32'hcafe_0400);
        drain_responses();

        // read-only region 0 overlaps region 1
        write_region(0, 1'b1, 1'b0, 32'h0000_0300, 32'h0000_03ff);
        send_req(OP_STORE, 32'h0000_0300, 4'hf, 32'hdead_beef);
        send_req(OP_LOAD, 32'h0000_0300, 4'h0, 32'h0);
        send_req(OP_STORE, 32'h0000_0400, 4'h3, 32'h0000_5a5a);
        send_req(OP_LOAD, 32'h0000_0400, 4'h0, 32'h0);
        drain_responses();

        // unmapped space inside an enabled region
        write_region(1, 1'b1, 1'b1, 32'h0, 32'hffff_ffff);
        send_req(OP_LOAD, 32'h0002_0000, 4'h0, 32'h0);
        send_req(OP_STORE, 32'h0002_0004, 4'hf, 32'h1234_5678);
        send_req(OP_LOAD, 32'hffff_fffc, 4'h0, 32'h0);
        drain_responses();

        // exclusive pairs
        send_req(OP_STORE, 32'h0001_0040, 4'hf, 32'h0000_0001);
        send_req(OP_LOAD_RES, 32'h0001_0040, 4'h0, 32'h0);
        send_req(OP_STORE_COND, 32'h0001_0040, 4'hf, 32'h0000_0002);
        send_req(OP_STORE_COND, 32'h0001_0040, 4'hf, 32'h0000_0003);
        send_req(OP_LOAD_RES, 32'h0001_0040, 4'h0, 32'h0);
        send_req(OP_STORE, 32'h0001_0040, 4'h1, 32'h0000_0044);
        send_req(OP_STORE_COND, 32'h0001_0040, 4'hf, 32'h0000_0005);
        send_req(OP_LOAD, 32'h0001_0040, 4'h0, 32'h0);
        drain_responses();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/mem_path_pkg.sv
rtl/access_check.sv
rtl/excl_monitor.sv
rtl/bank_access.sv
rtl/mem_path_top.sv
verification/mem_path_checker.sv
verification/mem_path_tb.sv

/* Bender.yml */
package:
  name: mem_path

sources:
  - files:
      - rtl/mem_path_pkg.sv
      - rtl/access_check.sv
      - rtl/excl_monitor.sv
      - rtl/bank_access.sv
      - rtl/mem_path_top.sv
  - target: test
    files:
      - verification/mem_path_checker.sv
      - verification/mem_path_tb.sv
